// ==== id_pkg.sv ====
// decode stage widths, opcode and operation enums, bus structs
`default_nettype none

package id_pkg;

  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;

  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    JAL    = 7'b1101111,
    BRANCH = 7'b1100011
  } opcode_e;

  // what execute computes
  typedef enum logic [3:0] {
    ADD      = 4'd0,
    SUB      = 4'd1,
    AND      = 4'd2,
    OR       = 4'd3,
    XOR      = 4'd4,
    SLT      = 4'd5,
    SLTU     = 4'd6,
    PASS_IMM = 4'd7
  } alu_op_e;

  // branch funct3 codes, JUMP sits on an unused funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    JUMP = 3'b010,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_func_e;

  typedef struct packed {
    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd;
    alu_op_e               alu_op;
    logic                  use_imm;   // imm replaces rs2_data
    logic                  gpr_wen;
    logic                  invalid_inst;
  } ds_to_es_t;

  typedef struct packed {
    logic                  wen;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } ws_to_rf_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } br_bus_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rs1_used;
    logic                  rs2_used;
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  gpr_wen;
    logic                  is_branch;  // branch or jal
    br_func_e              br_func;
    logic                  invalid_inst;
  } dec_ctrl_t;

endpackage

`default_nettype wire

// ==== id_stage_latch.sv ====
// fetch to decode pipeline latch: valid bit, instruction register, allowin and fire
`default_nettype none

module id_stage_latch (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_fs_to_ds_valid,
  input  id_pkg::fs_to_ds_t i_fs_to_ds_bus,
  input  logic              i_ready_go,
  input  logic              i_es_allowin,
  output logic              o_ds_valid,
  output logic              o_ds_allowin,
  output logic              o_fire,
  output id_pkg::fs_to_ds_t o_ds_bus
);

  logic              ds_valid;
  id_pkg::fs_to_ds_t ds_bus;

  // item leaves this cycle
  assign o_fire       = ds_valid && i_ready_go && i_es_allowin;
  assign o_ds_allowin = !ds_valid || (i_ready_go && i_es_allowin);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;  // empties when fetch has nothing
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_bus <= i_fs_to_ds_bus;
    end
  end

  assign o_ds_valid = ds_valid;
  assign o_ds_bus   = ds_bus;

  // held item must not change under a stall or back-pressure
  a_hold_stable: assert property (
    @(posedge i_clk) disable iff (i_reset)
    (o_ds_valid && !o_fire) |=> $stable(o_ds_bus)
  ) else $error("decode latch changed while holding");

endmodule

`default_nettype wire

// ==== id_decoder.sv ====
// instruction decoder: field extraction, immediates and control for the integer subset
`default_nettype none

module id_decoder (
  input  logic [id_pkg::INST_W-1:0] i_inst,
  output id_pkg::dec_ctrl_t         o_ctrl
);

  id_pkg::opcode_e         opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [id_pkg::XLEN-1:0] imm_i;
  logic [id_pkg::XLEN-1:0] imm_u;
  logic [id_pkg::XLEN-1:0] imm_b;
  logic [id_pkg::XLEN-1:0] imm_j;

  assign opcode = id_pkg::opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  // sign extended to xlen
  assign imm_i = {{(id_pkg::XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(id_pkg::XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_b = {{(id_pkg::XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_j = {{(id_pkg::XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    o_ctrl         = '0;
    o_ctrl.rs1     = i_inst[19:15];
    o_ctrl.rs2     = i_inst[24:20];
    o_ctrl.rd      = i_inst[11:7];
    o_ctrl.alu_op  = id_pkg::ADD;
    o_ctrl.br_func = id_pkg::BEQ;

    case (opcode)
      id_pkg::OP_IMM: begin
        o_ctrl.rs1_used = 1'b1;
        o_ctrl.use_imm  = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.imm      = imm_i;
        case (funct3)
          3'b000:  o_ctrl.alu_op = id_pkg::ADD;
          3'b111:  o_ctrl.alu_op = id_pkg::AND;
          3'b110:  o_ctrl.alu_op = id_pkg::OR;
          3'b100:  o_ctrl.alu_op = id_pkg::XOR;
          3'b010:  o_ctrl.alu_op = id_pkg::SLT;
          3'b011:  o_ctrl.alu_op = id_pkg::SLTU;
          default: o_ctrl.invalid_inst = 1'b1;  // shifts not supported
        endcase
      end
      id_pkg::OP: begin
        o_ctrl.rs1_used = 1'b1;
        o_ctrl.rs2_used = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: o_ctrl.alu_op = id_pkg::ADD;
          {7'h20, 3'b000}: o_ctrl.alu_op = id_pkg::SUB;
          {7'h00, 3'b111}: o_ctrl.alu_op = id_pkg::AND;
          {7'h00, 3'b110}: o_ctrl.alu_op = id_pkg::OR;
          {7'h00, 3'b100}: o_ctrl.alu_op = id_pkg::XOR;
          {7'h00, 3'b010}: o_ctrl.alu_op = id_pkg::SLT;
          {7'h00, 3'b011}: o_ctrl.alu_op = id_pkg::SLTU;
          default:         o_ctrl.invalid_inst = 1'b1;
        endcase
      end
      id_pkg::LUI: begin
        o_ctrl.imm     = imm_u;
        o_ctrl.alu_op  = id_pkg::PASS_IMM;
        o_ctrl.use_imm = 1'b1;
        o_ctrl.gpr_wen = 1'b1;
      end
      id_pkg::JAL: begin
        o_ctrl.imm       = imm_j;
        o_ctrl.gpr_wen   = 1'b1;  // link value formed in execute
        o_ctrl.is_branch = 1'b1;
        o_ctrl.br_func   = id_pkg::JUMP;
      end
      id_pkg::BRANCH: begin
        o_ctrl.rs1_used  = 1'b1;
        o_ctrl.rs2_used  = 1'b1;
        o_ctrl.imm       = imm_b;
        o_ctrl.is_branch = 1'b1;
        o_ctrl.br_func   = id_pkg::br_func_e'(funct3);
        if (funct3 == 3'b010 || funct3 == 3'b011) begin
          o_ctrl.invalid_inst = 1'b1;
        end
      end
      default: o_ctrl.invalid_inst = 1'b1;
    endcase

    // nothing outside the subset may write or redirect
    if (o_ctrl.invalid_inst) begin
      o_ctrl.gpr_wen   = 1'b0;
      o_ctrl.is_branch = 1'b0;
      o_ctrl.rs1_used  = 1'b0;
      o_ctrl.rs2_used  = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== id_gpr_file.sv ====
// general register file, 32 x 64, two async read ports and one write port
`default_nettype none

module id_gpr_file (
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  logic [id_pkg::REG_ADDR_W-1:0] i_raddr1,
  input  logic [id_pkg::REG_ADDR_W-1:0] i_raddr2,
  output logic [id_pkg::XLEN-1:0]       o_rdata1,
  output logic [id_pkg::XLEN-1:0]       o_rdata2,
  input  id_pkg::ws_to_rf_t             i_wr
);

  logic [id_pkg::XLEN-1:0] regs [32];  // x0 kept at zero by the write guard

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.wen && i_wr.waddr != '0) begin
      regs[i_wr.waddr] <= i_wr.wdata;
    end
  end

  // new value visible only after the write edge
  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

  a_x0_zero: assert property (
    @(posedge i_clk) disable iff (i_reset)
    (i_raddr1 != '0 || o_rdata1 == '0) && (i_raddr2 != '0 || o_rdata2 == '0)
  ) else $error("x0 read returned nonzero");

endmodule

`default_nettype wire

// ==== id_hazard_check.sv ====
// read-after-write check of decode sources against execute, memory and write-back rd
`default_nettype none

module id_hazard_check (
  input  logic                          i_ds_valid,
  input  id_pkg::dec_ctrl_t             i_ctrl,
  input  logic [id_pkg::REG_ADDR_W-1:0] i_es_rd,
  input  logic [id_pkg::REG_ADDR_W-1:0] i_ms_rd,
  input  logic [id_pkg::REG_ADDR_W-1:0] i_ws_rd,
  output logic                          o_ready_go
);

  logic es_hit;
  logic ms_hit;
  logic ws_hit;

  // rd 0 never produces a value
  assign es_hit = (i_es_rd != '0) &&
                  ((i_ctrl.rs1_used && i_es_rd == i_ctrl.rs1) ||
                   (i_ctrl.rs2_used && i_es_rd == i_ctrl.rs2));
  assign ms_hit = (i_ms_rd != '0) &&
                  ((i_ctrl.rs1_used && i_ms_rd == i_ctrl.rs1) ||
                   (i_ctrl.rs2_used && i_ms_rd == i_ctrl.rs2));
  assign ws_hit = (i_ws_rd != '0) &&
                  ((i_ctrl.rs1_used && i_ws_rd == i_ctrl.rs1) ||
                   (i_ctrl.rs2_used && i_ws_rd == i_ctrl.rs2));

  assign o_ready_go = !(i_ds_valid && (es_hit || ms_hit || ws_hit));

endmodule

`default_nettype wire

// ==== id_branch_unit.sv ====
// branch unit: operand compare, condition select and target for branches and jal
`default_nettype none

module id_branch_unit (
  input  logic                    i_fire,
  input  id_pkg::dec_ctrl_t       i_ctrl,
  input  logic [id_pkg::XLEN-1:0] i_pc,
  input  logic [id_pkg::XLEN-1:0] i_rs1_data,
  input  logic [id_pkg::XLEN-1:0] i_rs2_data,
  output id_pkg::br_bus_t         o_br_bus
);

  logic eq;
  logic lt;
  logic ltu;
  logic cond;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_ctrl.br_func)
      id_pkg::BEQ:  cond = eq;
      id_pkg::BNE:  cond = !eq;
      id_pkg::BLT:  cond = lt;
      id_pkg::BGE:  cond = !lt;
      id_pkg::BLTU: cond = ltu;
      id_pkg::BGEU: cond = !ltu;
      id_pkg::JUMP: cond = 1'b1;  // jal always
      default:      cond = 1'b0;
    endcase
  end

  // only redirect fetch when the item actually leaves
  assign o_br_bus.taken  = i_fire && i_ctrl.is_branch && cond;
  assign o_br_bus.target = i_pc + i_ctrl.imm;

  // decoder keeps invalid encodings off the branch bus
  always_comb begin
    assert (!o_br_bus.taken || (i_fire && !i_ctrl.invalid_inst))
      else $error("branch taken without fire or on invalid inst");
  end

endmodule

`default_nettype wire

// ==== id_stage.sv ====
// decode stage top: latch, decoder, register file, hazard check and branch unit
`default_nettype none

module id_stage (
  input  logic                          i_clk,
  input  logic                          i_reset,
  // from fetch
  input  logic                          i_fs_to_ds_valid,
  input  id_pkg::fs_to_ds_t             i_fs_to_ds_bus,
  output logic                          o_ds_allowin,
  // to execute
  output logic                          o_ds_to_es_valid,
  output id_pkg::ds_to_es_t             o_ds_to_es_bus,
  input  logic                          i_es_allowin,
  // to fetch
  output id_pkg::br_bus_t               o_br_bus,
  input  id_pkg::ws_to_rf_t             i_ws_to_rf_bus,
  // downstream destinations
  input  logic [id_pkg::REG_ADDR_W-1:0] i_es_rd,
  input  logic [id_pkg::REG_ADDR_W-1:0] i_ms_rd,
  input  logic [id_pkg::REG_ADDR_W-1:0] i_ws_rd
);

  logic                    ds_valid;
  logic                    ready_go;
  logic                    fire;
  id_pkg::fs_to_ds_t       ds_bus;
  id_pkg::dec_ctrl_t       ctrl;
  logic [id_pkg::XLEN-1:0] rs1_data;
  logic [id_pkg::XLEN-1:0] rs2_data;

  id_stage_latch u_latch (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_to_ds_bus   (i_fs_to_ds_bus),
    .i_ready_go       (ready_go),
    .i_es_allowin     (i_es_allowin),
    .o_ds_valid       (ds_valid),
    .o_ds_allowin     (o_ds_allowin),
    .o_fire           (fire),
    .o_ds_bus         (ds_bus)
  );

  id_decoder u_decoder (
    .i_inst (ds_bus.inst),
    .o_ctrl (ctrl)
  );

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_raddr1 (ctrl.rs1),
    .i_raddr2 (ctrl.rs2),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data),
    .i_wr     (i_ws_to_rf_bus)
  );

  id_hazard_check u_hazard_check (
    .i_ds_valid (ds_valid),
    .i_ctrl     (ctrl),
    .i_es_rd    (i_es_rd),
    .i_ms_rd    (i_ms_rd),
    .i_ws_rd    (i_ws_rd),
    .o_ready_go (ready_go)
  );

  id_branch_unit u_branch_unit (
    .i_fire     (fire),
    .i_ctrl     (ctrl),
    .i_pc       (ds_bus.pc),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_br_bus   (o_br_bus)
  );

  assign o_ds_to_es_valid = ds_valid && ready_go;

  assign o_ds_to_es_bus.pc           = ds_bus.pc;
  assign o_ds_to_es_bus.rs1_data     = rs1_data;
  assign o_ds_to_es_bus.rs2_data     = rs2_data;
  assign o_ds_to_es_bus.imm          = ctrl.imm;
  assign o_ds_to_es_bus.rd           = ctrl.rd;
  assign o_ds_to_es_bus.alu_op       = ctrl.alu_op;
  assign o_ds_to_es_bus.use_imm      = ctrl.use_imm;
  assign o_ds_to_es_bus.gpr_wen      = ctrl.gpr_wen;
  assign o_ds_to_es_bus.invalid_inst = ctrl.invalid_inst;

endmodule

`default_nettype wire

// ==== tb_id_stage.sv ====
// testbench for the decode stage: clock, reset, lfsr, stimulus table, loop and checks
`default_nettype none

module tb_id_stage;

  localparam int MAX_ENTRIES = 32;
  localparam int TIMEOUT     = 40;

  typedef struct packed {
    logic                  pre_en;
    logic [4:0]            pre_reg;
    logic                  pre_rand;  // value from the lfsr
    logic [63:0]           pre_val;
    logic [31:0]           inst;
    logic [63:0]           pc;
    logic [4:0]            es_rd;
    logic [4:0]            ms_rd;
    logic [4:0]            ws_rd;
    logic                  es_allowin;
    logic [3:0]            hold;      // cycles held before release
    logic                  exp_stall;
    id_pkg::alu_op_e       exp_alu;
    logic [63:0]           exp_imm;
    logic                  exp_use_imm;
    logic                  exp_wen;
    logic                  exp_invalid;
    logic                  exp_taken;
    logic [63:0]           exp_target;
  } entry_t;

  logic                          clk;
  logic                          reset;
  logic                          fs_valid;
  id_pkg::fs_to_ds_t             fs_bus;
  logic                          ds_allowin;
  logic                          es_valid;
  id_pkg::ds_to_es_t             es_bus;
  logic                          es_allowin;
  id_pkg::br_bus_t               br_bus;
  id_pkg::ws_to_rf_t             ws_bus;
  logic [id_pkg::REG_ADDR_W-1:0] es_rd;
  logic [id_pkg::REG_ADDR_W-1:0] ms_rd;
  logic [id_pkg::REG_ADDR_W-1:0] ws_rd;

  entry_t      t [MAX_ENTRIES];
  string       names [MAX_ENTRIES];
  logic [63:0] shadow [32];  // expected register contents
  logic [31:0] lfsr = 32'd71007;
  int          n = 0;
  int          passed = 0;
  int          failed = 0;
  logic        test_fail;
  logic        aborted = 1'b0;

  id_stage DUT (
    .i_clk            (clk),
    .i_reset          (reset),
    .i_fs_to_ds_valid (fs_valid),
    .i_fs_to_ds_bus   (fs_bus),
    .o_ds_allowin     (ds_allowin),
    .o_ds_to_es_valid (es_valid),
    .o_ds_to_es_bus   (es_bus),
    .i_es_allowin     (es_allowin),
    .o_br_bus         (br_bus),
    .i_ws_to_rf_bus   (ws_bus),
    .i_es_rd          (es_rd),
    .i_ms_rd          (ms_rd),
    .i_ws_rd          (ws_rd)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // 32-bit galois lfsr, one bit per step
  function automatic logic [63:0] rand64();
    logic [63:0] v;
    v = '0;
    for (int b = 0; b < 64; b++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BC_D35C) : (lfsr >> 1);
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, id_pkg::OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, id_pkg::OP_IMM};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] i, input logic [2:0] f3);
    return {i[12], i[10:5], 5'd9, 5'd8, f3, i[4:1], i[11], id_pkg::BRANCH};  // x8 vs x9
  endfunction

  task automatic add_entry(input string name, input logic pre_en, input logic [4:0] pre_reg,
                           input logic pre_rand, input logic [63:0] pre_val,
                           input logic [31:0] inst, input id_pkg::alu_op_e alu,
                           input logic [63:0] imm, input logic use_imm,
                           input logic wen, input logic inv);
    names[n] = name;
    t[n] = '0;
    t[n].pre_en = pre_en;
    t[n].pre_reg = pre_reg;
    t[n].pre_rand = pre_rand;
    t[n].pre_val = pre_val;
    t[n].inst = inst;
    t[n].pc = 64'h1000 + 64'(n) * 64'd4;
    t[n].es_allowin = 1'b1;
    t[n].exp_alu = alu;
    t[n].exp_imm = imm;
    t[n].exp_use_imm = use_imm;
    t[n].exp_wen = wen;
    t[n].exp_invalid = inv;
    t[n].exp_target = t[n].pc + imm;  // pc + imm for every instruction
    n++;
  endtask

  // x8 = all ones, x9 = 1, so signed and unsigned order differ
  task automatic add_branch(input string name, input logic [2:0] f3,
                            input logic [63:0] off, input logic taken);
    add_entry(name, 1'b0, 5'd0, 1'b0, 64'd0, enc_b(off[12:0], f3), id_pkg::ADD, off,
              1'b0, 1'b0, 1'b0);
    t[n-1].exp_taken = taken;
  endtask

  task automatic set_hazard(input logic [4:0] e, input logic [4:0] m, input logic [4:0] w,
                            input logic stall);
    t[n-1].es_rd = e;
    t[n-1].ms_rd = m;
    t[n-1].ws_rd = w;
    t[n-1].exp_stall = stall;
    t[n-1].hold = stall ? 4'd3 : 4'd0;
  endtask

  task automatic check(input string name, input string what,
                       input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("Error %s %s expected %h actual %h", name, what, exp, act);
      test_fail = 1'b1;
    end
  endtask

  // samples just before the rising edge where the item leaves
  task automatic wait_fire(input string name);
    int cnt;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (!(es_valid && es_allowin) && cnt < TIMEOUT);
    if (!(es_valid && es_allowin)) begin
      $display("timeout in %s, item never left decode", name);
      aborted = 1'b1;
    end
  endtask

  task automatic run_entry(input int i);
    entry_t            e;
    logic [63:0]       val;
    id_pkg::ds_to_es_t held;
    int                cnt;
    e = t[i];
    @(negedge clk);
    if (e.pre_en) begin
      if (e.pre_rand) val = rand64();
      else val = e.pre_val;
      ws_bus = '{wen: 1'b1, waddr: e.pre_reg, wdata: val};
      if (e.pre_reg != 5'd0) shadow[e.pre_reg] = val;  // x0 ignores writes
      @(negedge clk);
      ws_bus.wen = 1'b0;
    end
    fs_valid = 1'b1;
    fs_bus = '{inst: e.inst, pc: e.pc};
    es_rd = e.es_rd;
    ms_rd = e.ms_rd;
    ws_rd = e.ws_rd;
    es_allowin = e.es_allowin;
    cnt = 0;
    while (!ds_allowin && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (cnt >= TIMEOUT) begin
      $display("timeout in %s, decode never accepted the instruction", names[i]);
      aborted = 1'b1;
      return;
    end
    @(negedge clk);
    fs_valid = (e.hold != 4'd0);  // fetch offers another item while held
    fs_bus = '{inst: ~e.inst, pc: ~e.pc};
    held = es_bus;
    check(names[i], "stall valid", 64'(!e.exp_stall), 64'(es_valid));
    for (int h = 0; h < e.hold; h++) begin
      check(names[i], "held valid", 64'(!e.exp_stall), 64'(es_valid));
      check(names[i], "held allowin", 64'd0, 64'(ds_allowin));
      check(names[i], "held taken", 64'd0, 64'(br_bus.taken));
      check(names[i], "held pc", held.pc, es_bus.pc);
      check(names[i], "held rs1_data", held.rs1_data, es_bus.rs1_data);
      check(names[i], "held imm", held.imm, es_bus.imm);
      @(negedge clk);
    end
    fs_valid = 1'b0;
    es_rd = '0;  // release stall and back-pressure
    ms_rd = '0;
    ws_rd = '0;
    es_allowin = 1'b1;
    wait_fire(names[i]);
    if (aborted) return;
    check(names[i], "alu_op", 64'(e.exp_alu), 64'(es_bus.alu_op));
    check(names[i], "imm", e.exp_imm, es_bus.imm);
    check(names[i], "use_imm", 64'(e.exp_use_imm), 64'(es_bus.use_imm));
    check(names[i], "gpr_wen", 64'(e.exp_wen), 64'(es_bus.gpr_wen));
    check(names[i], "invalid", 64'(e.exp_invalid), 64'(es_bus.invalid_inst));
    check(names[i], "rd", 64'(e.inst[11:7]), 64'(es_bus.rd));
    check(names[i], "rs1_data", shadow[e.inst[19:15]], es_bus.rs1_data);
    check(names[i], "rs2_data", shadow[e.inst[24:20]], es_bus.rs2_data);
    check(names[i], "pc", e.pc, es_bus.pc);
    check(names[i], "taken", 64'(e.exp_taken), 64'(br_bus.taken));
    check(names[i], "target", e.exp_target, br_bus.target);
  endtask

  initial begin
    reset = 1'b1;
    fs_valid = 1'b0;
    fs_bus = '0;
    es_allowin = 1'b1;
    ws_bus = '0;
    es_rd = '0;
    ms_rd = '0;
    ws_rd = '0;
    for (int r = 0; r < 32; r++) shadow[r] = '0;

    add_entry("add_x8", 1, 5'd8, 0, '1, enc_r(7'h00, 5'd0, 5'd8, 3'b000, 5'd10),
              id_pkg::ADD, 64'd0, 0, 1, 0);
    add_entry("add_x9", 1, 5'd9, 0, 64'd1, enc_r(7'h00, 5'd9, 5'd8, 3'b000, 5'd11),
              id_pkg::ADD, 64'd0, 0, 1, 0);
    add_entry("add_rand", 1, 5'd5, 1, 64'd0, enc_r(7'h00, 5'd8, 5'd5, 3'b000, 5'd6),
              id_pkg::ADD, 64'd0, 0, 1, 0);
    add_entry("add_x0", 1, 5'd0, 1, 64'd0, enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd7),
              id_pkg::ADD, 64'd0, 0, 1, 0);
    add_entry("addi_neg", 0, 5'd0, 0, 64'd0, enc_i(12'hFFB, 5'd5, 3'b000, 5'd3),
              id_pkg::ADD, 64'hFFFF_FFFF_FFFF_FFFB, 1, 1, 0);
    add_entry("lui", 0, 5'd0, 0, 64'd0, {20'h12345, 5'd4, id_pkg::LUI},
              id_pkg::PASS_IMM, 64'h1234_5000, 1, 1, 0);
    add_entry("sub", 0, 5'd0, 0, 64'd0, enc_r(7'h20, 5'd9, 5'd8, 3'b000, 5'd1),
              id_pkg::SUB, 64'd0, 0, 1, 0);
    add_entry("sltu", 0, 5'd0, 0, 64'd0, enc_r(7'h00, 5'd9, 5'd8, 3'b011, 5'd2),
              id_pkg::SLTU, 64'd0, 0, 1, 0);
    add_entry("unknown", 0, 5'd0, 0, 64'd0, 32'h0000_0007, id_pkg::ADD, 64'd0, 0, 0, 1);
    add_branch("beq", 3'b000, 64'd16, 1'b0);
    add_branch("bne", 3'b001, 64'hFFFF_FFFF_FFFF_FFF8, 1'b1);
    add_branch("blt", 3'b100, 64'd16, 1'b1);
    add_branch("bge", 3'b101, 64'd16, 1'b0);
    add_branch("bltu", 3'b110, 64'd16, 1'b0);
    add_branch("bgeu", 3'b111, 64'd32, 1'b1);
    add_entry("jal", 0, 5'd0, 0, 64'd0, {1'b0, 10'h080, 1'b0, 8'h00, 5'd1, id_pkg::JAL},
              id_pkg::ADD, 64'd256, 0, 1, 0);
    t[n-1].exp_taken = 1'b1;
    add_branch("bne_held", 3'b001, 64'd12, 1'b1);
    t[n-1].es_allowin = 1'b0;
    t[n-1].hold = 4'd3;
    add_entry("haz_es", 0, 5'd0, 0, 64'd0, enc_r(7'h00, 5'd8, 5'd5, 3'b000, 5'd6),
              id_pkg::ADD, 64'd0, 0, 1, 0);
    set_hazard(5'd5, 5'd0, 5'd0, 1'b1);
    add_entry("haz_ms_rs2", 0, 5'd0, 0, 64'd0, enc_r(7'h00, 5'd8, 5'd5, 3'b000, 5'd6),
              id_pkg::ADD, 64'd0, 0, 1, 0);
    set_hazard(5'd0, 5'd8, 5'd0, 1'b1);
    add_entry("haz_ws", 0, 5'd0, 0, 64'd0, enc_r(7'h00, 5'd8, 5'd5, 3'b000, 5'd6),
              id_pkg::ADD, 64'd0, 0, 1, 0);
    set_hazard(5'd0, 5'd0, 5'd5, 1'b1);
    add_entry("rd_zero", 0, 5'd0, 0, 64'd0, enc_i(12'd1, 5'd0, 3'b000, 5'd3),
              id_pkg::ADD, 64'd1, 1, 1, 0);
    set_hazard(5'd0, 5'd0, 5'd0, 1'b0);
    add_entry("addi_rs2", 0, 5'd0, 0, 64'd0, enc_i(12'd8, 5'd5, 3'b000, 5'd3),
              id_pkg::ADD, 64'd8, 1, 1, 0);
    set_hazard(5'd8, 5'd8, 5'd8, 1'b0);
    add_entry("backpressure", 0, 5'd0, 0, 64'd0, enc_r(7'h00, 5'd9, 5'd5, 3'b100, 5'd6),
              id_pkg::XOR, 64'd0, 0, 1, 0);
    t[n-1].es_allowin = 1'b0;
    t[n-1].hold = 4'd3;
    add_entry("after_bp", 0, 5'd0, 0, 64'd0, enc_i(12'h7FF, 5'd9, 3'b111, 5'd6),
              id_pkg::AND, 64'h7FF, 1, 1, 0);

    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_fail = 1'b0;
    check("reset", "valid", 64'd0, 64'(es_valid));
    check("reset", "allowin", 64'd1, 64'(ds_allowin));
    check("reset", "taken", 64'd0, 64'(br_bus.taken));
    $display("test reset %s", test_fail ? "failed" : "ok");
    if (test_fail) failed++;
    else passed++;

    for (int i = 0; i < n; i++) begin
      test_fail = 1'b0;
      run_entry(i);
      if (test_fail || aborted) failed++;
      else passed++;
      $display("test %s %s", names[i], (test_fail || aborted) ? "failed" : "ok");
      if (aborted) break;
    end

    $display("tests passed %0d failed %0d", passed, failed);
    if (failed == 0 && !aborted) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
id_pkg.sv
id_stage_latch.sv
id_decoder.sv
id_gpr_file.sv
id_hazard_check.sv
id_branch_unit.sv
id_stage.sv
tb_id_stage.sv

// ==== Makefile ====
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
